// File: comp_mult_top.f
hw/cmul_types_pkg.sv
hw/cmul_regmap_pkg.sv
hw/cmul_mult_if.sv
hw/cmul_seq_if.sv
hw/cmul_apb_regs.sv
hw/cmul_ctrl.sv
hw/cmul_mem_seq.sv
hw/cmul_core.sv
hw/comp_mult_top.sv
verification/cmul_checker.sv
verification/tb_comp_mult_top.sv

// File: hw/cmul_apb_regs.sv
// register window at APB_BASE, only status and state are readable
// pready tied high, read data and pslverr arrive the cycle after select
`timescale 1ns/1ps
module cmul_apb_regs
    import cmul_types_pkg::*;
    import cmul_regmap_pkg::*;
#(
    parameter addr_t APB_BASE = '0  // register base address
) (
    input  logic        clk,
    input  logic        rst_n,
    input  addr_t       paddr,
    input  logic        pwrite,
    input  reg_t        pwdata,
    input  logic        psel,
    input  logic        finish,    // run complete, sets done
    input  ctrl_state_e state,     // live fsm state
    output logic        pready,
    output reg_t        prdata,
    output logic        pslverr,
    output addr_t       op1_base,
    output addr_t       op2_base,
    output addr_t       res_base,
    output reg_t        num_op,
    output logic        start      // one-cycle start pulse
);
    addr_t       ofs_full;  // offset from base
    reg_offset_e ofs;
    logic        in_range;  // offset inside the 8-word window
    logic        acc_ok;    // offset allows this direction
    logic        wr_en;
    logic        rd_en;
    logic        done;

    assign pready   = 1'b1;
    assign ofs_full = paddr - APB_BASE;             // below base wraps out of range
    assign in_range = (ofs_full[ADDR_W-1:3] == '0);
    assign ofs      = reg_offset_e'(ofs_full[2:0]);

    always_comb begin
        case (ofs)
            OFS_OP1, OFS_OP2, OFS_RES, OFS_NUM_OP, OFS_START: acc_ok = pwrite;
            OFS_STATUS: acc_ok = 1'b1;     // clear by writing 0
            OFS_STATE:  acc_ok = ~pwrite;  // mirror only
            default:    acc_ok = 1'b0;     // offset 7 unmapped
        endcase
    end

    assign wr_en = psel & pwrite & in_range & acc_ok;
    assign rd_en = psel & ~pwrite & in_range & acc_ok;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op1_base <= '0;
            op2_base <= '0;
            res_base <= '0;
            num_op   <= '0;
            start    <= 1'b0;
            done     <= 1'b0;
            pslverr  <= 1'b0;
            prdata   <= '0;
        end else begin
            start   <= wr_en & (ofs == OFS_START) & pwdata[0];  // auto clears
            pslverr <= psel & ~(in_range & acc_ok);             // bad offset or direction
            if (wr_en) begin
                case (ofs)
                    OFS_OP1:    op1_base <= pwdata;
                    OFS_OP2:    op2_base <= pwdata;
                    OFS_RES:    res_base <= pwdata;
                    OFS_NUM_OP: num_op   <= pwdata;
                    default: ;
                endcase
            end
            if (finish) begin
                done <= 1'b1;  // finish wins over a clear
            end else if (wr_en && ofs == OFS_STATUS && !pwdata[STS_DONE_BIT]) begin
                done <= 1'b0;
            end
            if (rd_en) begin
                prdata <= (ofs == OFS_STATE) ? reg_t'(state) : reg_t'(done) << STS_DONE_BIT;
            end
        end
    end

endmodule

// File: hw/cmul_core.sv
// two-stage signed complex multiplier, result valid 2 cycles after acceptance
// stalls while the result is held and res_rdy is low
`timescale 1ns/1ps
module cmul_core
    import cmul_types_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    cmul_mult_if.core mult
);
    elem_t x1;
    elem_t y1;
    elem_t x2;
    elem_t y2;
    res_t  p_xx;    // x1*x2
    res_t  p_yy;    // y1*y2
    res_t  p_xy;    // x1*y2
    res_t  p_yx;    // y1*x2
    res_t  xr;
    res_t  yr;
    logic  s1_val;  // products valid
    logic  stall;   // output held

    assign {x1, y1, x2, y2} = mult.op_data;

    assign stall         = mult.res_val & ~mult.res_rdy;
    assign mult.op_rdy   = ~s1_val | ~stall;  // stage one empty or moving on
    assign mult.res_data = {xr, yr};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_val       <= 1'b0;
            mult.res_val <= 1'b0;
        end else begin
            if (mult.op_rdy)
                s1_val <= mult.op_val;
            if (!stall)
                mult.res_val <= s1_val;
        end
    end

    // operands widen to 18 bits before multiply
    always_ff @(posedge clk) begin
        if (mult.op_val && mult.op_rdy) begin
            p_xx <= x1 * x2;
            p_yy <= y1 * y2;
            p_xy <= x1 * y2;
            p_yx <= y1 * x2;
        end
        if (s1_val && !stall) begin
            xr <= p_xx - p_yy;  // real part
            yr <= p_xy + p_yx;  // imaginary part
        end
    end

endmodule

// File: hw/cmul_ctrl.sv
// operation fsm, one read/multiply/write pass per operation
// start with a zero count is ignored, start during a run as well
`timescale 1ns/1ps
module cmul_ctrl
    import cmul_types_pkg::*;
    import cmul_regmap_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        start,
    input  reg_t        num_op,
    cmul_seq_if.ctrl    seq,
    output logic        finish,  // pulse after the last result byte
    output ctrl_state_e state
);
    ctrl_state_e state_nxt;
    reg_t        op_done_cnt;  // operations completed this run
    logic        go;           // accepted start
    logic        last_op;

    assign go      = (state == ST_IDLE) & start & (num_op != '0);
    assign last_op = (op_done_cnt == num_op - 1'b1);

    assign seq.cmd_first = go;
    assign seq.cmd_rd    = go | ((state == ST_WR_RES) & seq.wr_done & ~last_op);
    assign seq.cmd_wr    = (state == ST_WORK) & seq.res_avail;
    assign finish        = (state == ST_WR_RES) & seq.wr_done & last_op;

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (go) state_nxt = ST_RD_OPS;
            end
            ST_RD_OPS: begin
                if (seq.rd_done) state_nxt = ST_WORK;  // operands handed to core
            end
            ST_WORK: begin
                if (seq.res_avail) state_nxt = ST_WR_RES;
            end
            ST_WR_RES: begin
                if (seq.wr_done) state_nxt = last_op ? ST_IDLE : ST_RD_OPS;
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= ST_IDLE;
            op_done_cnt <= '0;
        end else begin
            state <= state_nxt;
            if (go) begin
                op_done_cnt <= '0;  // new run
            end else if (state == ST_WR_RES && seq.wr_done) begin
                op_done_cnt <= op_done_cnt + 1'b1;
            end
        end
    end

endmodule

// File: hw/cmul_mem_seq.sv
// memory bursts: 4 operand reads, 6 result writes, one shared byte counter
// read data is taken one cycle after the request, memory has no back-pressure
`timescale 1ns/1ps
module cmul_mem_seq
    import cmul_types_pkg::*;
    import cmul_regmap_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  addr_t    op1_base,
    input  addr_t    op2_base,
    input  addr_t    res_base,
    input  elem_t    mem_rd_data,
    output logic     mem_ce,
    output logic     mem_we,
    output addr_t    mem_addr,
    output elem_t    mem_wr_data,
    cmul_seq_if.seq  seq,
    cmul_mult_if.seq mult
);
    addr_t     op1_ptr;   // running operand 1 address
    addr_t     op2_ptr;   // running operand 2 address
    addr_t     res_ptr;   // running result address
    byte_cnt_t byte_cnt;  // byte index in current burst
    logic      rd_act;    // read burst on the bus
    logic      wr_act;    // write burst on the bus
    logic      rd_end;    // last read request
    logic      rd_vld;    // read data returning
    byte_cnt_t rd_idx;    // index of returning byte
    logic      op_hold;   // operands not yet taken by core
    logic      res_take;  // core result into buffer
    logic      res_full_nxt;
    logic      res_full;
    res_t      res_comp;  // component being written
    byte_cnt_t res_idx;   // byte within component
    logic [4*ELEM_W-1:0]         op_q;     // operand bytes, x1 on top
    logic [2*RES_W-1:0]          res_q;    // result buffer {xr, yr}
    logic [RES_BYTES*ELEM_W-1:0] res_ext;  // component zero-filled to bytes

    assign mem_ce      = rd_act | wr_act;
    assign mem_we      = wr_act;
    assign rd_end      = rd_act & (byte_cnt == byte_cnt_t'(OP_RD_BYTES - 1));
    assign seq.wr_done = wr_act & (byte_cnt == byte_cnt_t'(RES_WR_BYTES - 1));
    assign seq.rd_done = rd_vld & (rd_idx == byte_cnt_t'(OP_RD_BYTES - 1));

    // x1 y1 from operand 1, x2 y2 from operand 2
    always_comb begin
        if (wr_act)
            mem_addr = res_ptr + addr_t'(byte_cnt);
        else if (byte_cnt < OP_STRIDE)
            mem_addr = op1_ptr + addr_t'(byte_cnt);
        else
            mem_addr = op2_ptr + addr_t'(byte_cnt) - addr_t'(OP_STRIDE);
    end

    // fourth byte goes to the core live, held copy only if core stalls
    assign mult.op_val  = seq.rd_done | op_hold;
    assign mult.op_data = op_hold ? op_q : {op_q[4*ELEM_W-1:ELEM_W], mem_rd_data};

    assign res_take     = mult.res_val & mult.res_rdy;
    assign res_full_nxt = (res_full | res_take) & ~seq.wr_done;  // freed by last write

    // yr bytes first, lsb first, top byte carries bits 17:16
    assign res_comp    = (byte_cnt < RES_BYTES) ? res_q[RES_W-1:0] : res_q[2*RES_W-1:RES_W];
    assign res_idx     = (byte_cnt < RES_BYTES) ? byte_cnt : byte_cnt_t'(byte_cnt - RES_BYTES);
    assign res_ext     = {{(RES_BYTES*ELEM_W-RES_W){1'b0}}, res_comp};
    assign mem_wr_data = res_ext[res_idx*ELEM_W +: ELEM_W];

    always_ff @(posedge clk) begin
        if (rd_vld)
            op_q[(OP_RD_BYTES-1-rd_idx)*ELEM_W +: ELEM_W] <= mem_rd_data;
        if (res_take)
            res_q <= mult.res_data;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op1_ptr       <= '0;
            op2_ptr       <= '0;
            res_ptr       <= '0;
            byte_cnt      <= '0;
            rd_act        <= 1'b0;
            wr_act        <= 1'b0;
            rd_vld        <= 1'b0;
            rd_idx        <= '0;
            op_hold       <= 1'b0;
            res_full      <= 1'b0;
            mult.res_rdy  <= 1'b0;
            seq.res_avail <= 1'b0;
        end else begin
            rd_vld        <= rd_act;                    // data follows request
            rd_idx        <= byte_cnt;
            op_hold       <= mult.op_val & ~mult.op_rdy;
            res_full      <= res_full_nxt;
            mult.res_rdy  <= ~res_full_nxt;             // ready only while empty
            seq.res_avail <= res_take;
            if (rd_end) begin
                rd_act  <= 1'b0;
                op1_ptr <= op1_ptr + addr_t'(OP_STRIDE);
                op2_ptr <= op2_ptr + addr_t'(OP_STRIDE);
            end
            if (seq.wr_done) begin
                wr_act  <= 1'b0;
                res_ptr <= res_ptr + addr_t'(RES_STRIDE);
            end
            if (seq.cmd_rd) begin
                rd_act   <= 1'b1;  // may directly follow the last write
                byte_cnt <= '0;
            end else if (seq.cmd_wr) begin
                wr_act   <= 1'b1;
                byte_cnt <= '0;
            end else if (mem_ce) begin
                byte_cnt <= byte_cnt + 1'b1;
            end
            if (seq.cmd_first) begin
                op1_ptr <= op1_base;  // new run
                op2_ptr <= op2_base;
                res_ptr <= res_base;
            end
        end
    end

endmodule

// File: hw/cmul_mult_if.sv
// valid/ready link to the multiplier, operands {x1, y1, x2, y2} msb first
// results {xr, yr}, valid holds with stable data until accepted
`timescale 1ns/1ps
interface cmul_mult_if
    import cmul_types_pkg::*;
();
    logic                op_val;
    logic                op_rdy;
    logic [4*ELEM_W-1:0] op_data;   // x1 in top byte
    logic                res_val;
    logic                res_rdy;
    logic [2*RES_W-1:0]  res_data;  // xr in top half

    modport seq (
        output op_val, op_data, res_rdy,
        input  op_rdy, res_val, res_data
    );

    modport core (
        input  op_val, op_data, res_rdy,
        output op_rdy, res_val, res_data
    );
endinterface

// File: hw/cmul_regmap_pkg.sv
// register offsets, status bits, control states and per-operation byte counts
// offsets are relative to the register base address
package cmul_regmap_pkg;

    typedef enum logic [2:0] {
        OFS_OP1    = 3'd0,  // operand 1 base, write only
        OFS_OP2    = 3'd1,  // operand 2 base, write only
        OFS_RES    = 3'd2,  // result base, write only
        OFS_NUM_OP = 3'd3,  // operation count, write only
        OFS_START  = 3'd4,  // start, self clearing
        OFS_STATUS = 3'd5,  // done flag, read/write
        OFS_STATE  = 3'd6   // fsm state, read only
    } reg_offset_e;

    localparam int STS_DONE_BIT = 0;

    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_RD_OPS = 2'd1,  // fetching four operand bytes
        ST_WORK   = 2'd2,  // waiting for the product
        ST_WR_RES = 2'd3   // storing six result bytes
    } ctrl_state_e;

    localparam int OP_RD_BYTES  = 4;  // x1 y1 x2 y2
    localparam int RES_WR_BYTES = 6;  // yr then xr, lsb first
    localparam int OP_STRIDE    = 2;  // bytes per complex operand
    localparam int RES_STRIDE   = 6;  // bytes per complex result

endpackage

// File: hw/cmul_seq_if.sv
// single-cycle command and completion pulses between controller and sequencer
`timescale 1ns/1ps
interface cmul_seq_if;
    logic cmd_rd;     // start one operand read burst
    logic cmd_first;  // with cmd_rd, reload pointers from registers
    logic cmd_wr;     // start one result write burst
    logic rd_done;    // last operand byte on the bus
    logic wr_done;    // last result byte written
    logic res_avail;  // result buffered from the core

    modport ctrl (
        output cmd_rd, cmd_first, cmd_wr,
        input  rd_done, wr_done, res_avail
    );

    modport seq (
        input  cmd_rd, cmd_first, cmd_wr,
        output rd_done, wr_done, res_avail
    );
endinterface

// File: hw/cmul_types_pkg.sv
// data widths and vector types of the engine
// element width is tied to the byte-wide memory, results are stored as 3 bytes
package cmul_types_pkg;

    localparam int ELEM_W    = 8;   // operand element, one memory byte
    localparam int RES_W     = 18;  // result component incl. growth
    localparam int RES_BYTES = 3;   // bytes per result component
    localparam int ADDR_W    = 16;  // memory byte address
    localparam int REG_W     = 16;  // apb register word

    typedef logic signed [ELEM_W-1:0] elem_t;      // x or y of one operand
    typedef logic signed [RES_W-1:0]  res_t;       // xr or yr, also products
    typedef logic [ADDR_W-1:0]        addr_t;      // memory byte address
    typedef logic [REG_W-1:0]         reg_t;       // register word
    typedef logic [2:0]               byte_cnt_t;  // up to 6 bytes per burst

endpackage

// File: hw/comp_mult_top.sv
// complex multiplier engine with apb-style registers and byte-wide sync memory
// memory read data is expected one cycle after the request
`timescale 1ns/1ps
module comp_mult_top
    import cmul_types_pkg::*;
    import cmul_regmap_pkg::*;
#(
    parameter addr_t APB_BASE = '0  // register base address
) (
    input  logic  clk,
    input  logic  rst_n,
    input  addr_t paddr,
    input  logic  pwrite,
    input  reg_t  pwdata,
    input  logic  psel,
    output logic  pready,
    output reg_t  prdata,
    output logic  pslverr,
    output logic  mem_ce,
    output logic  mem_we,
    output addr_t mem_addr,
    output elem_t mem_wr_data,
    input  elem_t mem_rd_data
);
    addr_t       op1_base;
    addr_t       op2_base;
    addr_t       res_base;
    reg_t        num_op;
    logic        start;
    logic        finish;
    ctrl_state_e state;

    cmul_seq_if  seq_if ();
    cmul_mult_if mult_if ();

    cmul_apb_regs #(
        .APB_BASE (APB_BASE)
    ) i_apb_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .paddr    (paddr),
        .pwrite   (pwrite),
        .pwdata   (pwdata),
        .psel     (psel),
        .finish   (finish),
        .state    (state),
        .pready   (pready),
        .prdata   (prdata),
        .pslverr  (pslverr),
        .op1_base (op1_base),
        .op2_base (op2_base),
        .res_base (res_base),
        .num_op   (num_op),
        .start    (start)
    );

    cmul_ctrl i_ctrl (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start),
        .num_op (num_op),
        .seq    (seq_if.ctrl),
        .finish (finish),
        .state  (state)
    );

    cmul_mem_seq i_mem_seq (
        .clk         (clk),
        .rst_n       (rst_n),
        .op1_base    (op1_base),
        .op2_base    (op2_base),
        .res_base    (res_base),
        .mem_rd_data (mem_rd_data),
        .mem_ce      (mem_ce),
        .mem_we      (mem_we),
        .mem_addr    (mem_addr),
        .mem_wr_data (mem_wr_data),
        .seq         (seq_if.seq),
        .mult        (mult_if.seq)
    );

    cmul_core i_core (
        .clk   (clk),
        .rst_n (rst_n),
        .mult  (mult_if.core)
    );

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f comp_mult_top.f \
    --top-module tb_comp_mult_top -o sim_comp_mult
./obj_dir/sim_comp_mult | tee sim.log
if ! grep -qx ">>> PASS" sim.log; then
    echo "simulation reported failure, see sim.log"
    exit 1
fi

// File: verification/cmul_checker.sv
// memory and apb monitor with a reference model, assumes APB_BASE of 0
// apb and read data sampled on rising edges, dut memory outputs on falling edges
`timescale 1ns/1ps
module cmul_checker
    import cmul_types_pkg::*;
    import cmul_regmap_pkg::*;
(
    input  logic  clk,
    input  addr_t paddr,
    input  logic  pwrite,
    input  reg_t  pwdata,
    input  logic  psel,
    input  logic  mem_ce,
    input  logic  mem_we,
    input  addr_t mem_addr,
    input  elem_t mem_wr_data,
    input  elem_t mem_rd_data,
    output int    err_cnt,
    output int    wr_cnt,
    output int    rd_cnt
);
    addr_t      op1_reg, op2_reg, res_reg;  // last programmed bases
    addr_t      op1_ptr, op2_ptr, res_ptr;  // expected running pointers
    addr_t      exp_a;
    logic       rd_req_q = 1'b0;            // read issued last cycle
    logic       rd_arrive = 1'b0;           // data on mem_rd_data now
    int         rd_idx = 0;
    int         wr_idx = 0;
    int         cap_idx = 0;
    int         xr, yr;
    logic [23:0] xb, yb;                    // components as 3 bytes
    elem_t      ops [4];                    // x1 y1 x2 y2
    logic [7:0] exp_q [$];                  // expected result bytes in write order

    initial begin
        err_cnt = 0;
        wr_cnt  = 0;
        rd_cnt  = 0;
    end

    task automatic report_mismatch(input string sig, input int exp_v, input int got_v);
        $display("[ERROR] %0t %s expected %0h got %0h", $time, sig, exp_v, got_v);
        err_cnt++;
    endtask

    // register writes and returning operand bytes
    always @(posedge clk) begin
        if (psel && pwrite) begin
            case (paddr)
                16'(OFS_OP1): op1_reg = pwdata;
                16'(OFS_OP2): op2_reg = pwdata;
                16'(OFS_RES): res_reg = pwdata;
                16'(OFS_START): begin
                    op1_ptr = op1_reg;  // new run reloads pointers
                    op2_ptr = op2_reg;
                    res_ptr = res_reg;
                    rd_idx  = 0;
                    wr_idx  = 0;
                end
                default: ;
            endcase
        end
        if (rd_arrive) begin
            ops[cap_idx] = mem_rd_data;
            cap_idx = (cap_idx + 1) % OP_RD_BYTES;
            if (cap_idx == 0) begin
                xr = int'(ops[0]) * int'(ops[2]) - int'(ops[1]) * int'(ops[3]);
                yr = int'(ops[0]) * int'(ops[3]) + int'(ops[1]) * int'(ops[2]);
                xb = 24'(xr) & 24'h03ffff;  // 18-bit two's complement, top zero
                yb = 24'(yr) & 24'h03ffff;
                exp_q.push_back(yb[7:0]);   // yr first, lsb first
                exp_q.push_back(yb[15:8]);
                exp_q.push_back(yb[23:16]);
                exp_q.push_back(xb[7:0]);
                exp_q.push_back(xb[15:8]);
                exp_q.push_back(xb[23:16]);
            end
        end
    end

    // memory requests, stable in the second half of the cycle
    always @(negedge clk) begin
        rd_arrive = rd_req_q;
        rd_req_q  = mem_ce && !mem_we;
        if (mem_ce && !mem_we) begin
            exp_a = (rd_idx < 2) ? op1_ptr + addr_t'(rd_idx) : op2_ptr + addr_t'(rd_idx - 2);
            if (mem_addr !== exp_a)
                report_mismatch("mem_addr", exp_a, mem_addr);
            rd_cnt++;
            rd_idx = (rd_idx + 1) % OP_RD_BYTES;
            if (rd_idx == 0) begin
                op1_ptr += addr_t'(OP_STRIDE);
                op2_ptr += addr_t'(OP_STRIDE);
            end
        end
        if (mem_ce && mem_we) begin
            wr_cnt++;
            exp_a = res_ptr + addr_t'(wr_idx);
            if (mem_addr !== exp_a)
                report_mismatch("mem_addr", exp_a, mem_addr);
            if (exp_q.size() == 0) begin
                $display("result byte written at %0t with no operands read for it", $time);
                err_cnt++;
            end else begin
                xb[7:0] = exp_q.pop_front();
                if (mem_wr_data !== xb[7:0])
                    report_mismatch("mem_wr_data", xb[7:0], 8'(mem_wr_data));
            end
            wr_idx = (wr_idx + 1) % RES_WR_BYTES;
            if (wr_idx == 0)
                res_ptr += addr_t'(RES_STRIDE);
        end
    end

endmodule

// File: verification/tb_comp_mult_top.sv
// testbench for comp_mult_top at APB_BASE 0, 64 KB byte memory answers one cycle late
// random operands and bases come from an lcg, results are compared in cmul_checker
`timescale 1ns/1ps
module tb_comp_mult_top
    import cmul_types_pkg::*;
    import cmul_regmap_pkg::*;
();
    localparam int MAX_OPS = 1 + 8 + 8;  // single + longest multi + extremes

    logic  clk, rst_n, psel, pwrite, pready, pslverr, mem_ce, mem_we;
    addr_t paddr, mem_addr;
    reg_t  pwdata, prdata;
    elem_t mem_wr_data, mem_rd_data;
    logic [7:0]  mem [0:65535];
    logic        rd_pend = 1'b0;  // read request waiting for data
    addr_t       rd_addr_q;
    logic [31:0] rng = 32'hae236adc;
    int   tb_errs = 0;
    int   tests_run = 0;
    int   tests_failed = 0;
    int   chk_errs, wr_cnt, rd_cnt;

    comp_mult_top i_dut (.*);

    cmul_checker i_chk (
        .clk(clk), .paddr(paddr), .pwrite(pwrite), .pwdata(pwdata), .psel(psel),
        .mem_ce(mem_ce), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_wr_data(mem_wr_data), .mem_rd_data(mem_rd_data),
        .err_cnt(chk_errs), .wr_cnt(wr_cnt), .rd_cnt(rd_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // sync memory, data shows up in the cycle after the request
    always @(negedge clk) begin
        if (rd_pend)
            mem_rd_data <= elem_t'(mem[rd_addr_q]);
        rd_pend   <= mem_ce & ~mem_we;
        rd_addr_q <= mem_addr;
        if (mem_ce && mem_we)
            mem[mem_addr] <= mem_wr_data;
    end

    initial begin
        repeat (200 * MAX_OPS + 2000) @(posedge clk);
        $display("watchdog expired, the run did not complete in time");
        $display(">>> FAIL");
        $finish;
    end

    function automatic logic [31:0] next_rand();
        rng = rng * 32'd1664525 + 32'd1013904223;
        return rng;
    endfunction

    task automatic check_value(input string sig, input int exp_v, input int got_v);
        if (exp_v != got_v) begin
            $display("[ERROR] %0t %s expected %0h got %0h", $time, sig, exp_v, got_v);
            tb_errs++;
        end
    endtask

    // one select cycle, read data and pslverr taken in the cycle after
    task automatic apb_access(input int ofs, input logic wr, input reg_t wdata,
                              output reg_t rdata, output logic err);
        @(negedge clk);
        psel   = 1'b1;
        pwrite = wr;
        paddr  = addr_t'(ofs);
        pwdata = wdata;
        @(negedge clk);
        check_value("pready", 1, pready);  // no wait states
        psel   = 1'b0;
        pwrite = 1'b0;
        rdata  = prdata;
        err    = pslverr;
    endtask

    task automatic finish_test(input string name, input int errs0);
        tests_run++;
        if (tb_errs + chk_errs != errs0) begin
            tests_failed++;
            $display("test %s: failed", name);
        end else begin
            $display("test %s: passed", name);
        end
    endtask

    task automatic pick_bases(output addr_t b1, output addr_t b2, output addr_t br);
        b1 = addr_t'(next_rand() >> 19);            // 0x0000..0x1fff
        b2 = 16'h4000 | addr_t'(next_rand() >> 19);  // separate 16 KB regions
        br = 16'h8000 | addr_t'(next_rand() >> 19);
    endtask

    task automatic run_ops(input string name, input addr_t b1, input addr_t b2,
                           input addr_t br, input int n);
        int   errs0;
        int   wr0;
        int   polls;
        reg_t rd;
        logic err;
        errs0 = tb_errs + chk_errs;
        wr0   = wr_cnt;
        apb_access(OFS_STATUS, 1'b1, '0, rd, err);  // done of an earlier run
        apb_access(OFS_OP1, 1'b1, b1, rd, err);
        apb_access(OFS_OP2, 1'b1, b2, rd, err);
        apb_access(OFS_RES, 1'b1, br, rd, err);
        apb_access(OFS_NUM_OP, 1'b1, reg_t'(n), rd, err);
        apb_access(OFS_START, 1'b1, 16'd1, rd, err);
        apb_access(OFS_STATE, 1'b0, '0, rd, err);
        if (rd == reg_t'(ST_IDLE)) begin
            $display("state register reads idle while a run is in progress");
            tb_errs++;
        end
        polls = 0;
        rd    = '0;
        while (!rd[STS_DONE_BIT] && polls < 100 * n + 100) begin  // poll done
            apb_access(OFS_STATUS, 1'b0, '0, rd, err);
            polls++;
        end
        if (!rd[STS_DONE_BIT]) begin
            $display("done bit never set in test %s", name);
            tb_errs++;
        end
        check_value("result_bytes", RES_WR_BYTES * n, wr_cnt - wr0);
        apb_access(OFS_STATE, 1'b0, '0, rd, err);
        check_value("state", ST_IDLE, rd);
        finish_test(name, errs0);
    endtask

    initial begin
        addr_t b1, b2, br;
        reg_t  rd;
        logic  err;
        int    errs0;
        int    acc0;
        rst_n = 1'b0;
        psel = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        mem_rd_data = '0;
        for (int a = 0; a < 65536; a++)
            mem[a] = 8'(next_rand() >> 16);  // random bytes over the whole range
        repeat (16) @(negedge clk);
        rst_n = 1'b1;

        pick_bases(b1, b2, br);
        run_ops("single", b1, b2, br, 1);
        pick_bases(b1, b2, br);
        run_ops("multi", b1, b2, br, 3 + int'(next_rand() >> 16) % 6);

        pick_bases(b1, b2, br);
        for (int i = 0; i < 16; i++) begin
            mem[b1 + addr_t'(i)] = 1'(next_rand() >> 20) ? 8'h80 : 8'h7f;  // -128 or 127
            mem[b2 + addr_t'(i)] = 1'(next_rand() >> 20) ? 8'h80 : 8'h7f;
        end
        run_ops("extremes", b1, b2, br, 8);

        errs0 = tb_errs + chk_errs;
        apb_access(OFS_STATUS, 1'b1, '0, rd, err);  // clear done
        apb_access(OFS_STATUS, 1'b0, '0, rd, err);
        check_value("done", 0, rd[STS_DONE_BIT]);
        apb_access(OFS_STATE, 1'b0, '0, rd, err);
        check_value("state", ST_IDLE, rd);
        finish_test("status", errs0);

        errs0 = tb_errs + chk_errs;
        apb_access(1'(next_rand() >> 18) ? 7 : 8 + int'(next_rand() >> 20),
                   1'(next_rand() >> 19), '0, rd, err);
        check_value("pslverr", 1, err);
        apb_access(OFS_OP1, 1'b0, '0, rd, err);
        check_value("pslverr", 1, err);
        apb_access(OFS_STATE, 1'b1, '0, rd, err);
        check_value("pslverr", 1, err);
        apb_access(OFS_STATUS, 1'b0, '0, rd, err);
        check_value("pslverr", 0, err);
        finish_test("slave_error", errs0);

        errs0 = tb_errs + chk_errs;
        acc0  = rd_cnt + wr_cnt;
        apb_access(OFS_NUM_OP, 1'b1, '0, rd, err);
        apb_access(OFS_START, 1'b1, 16'd1, rd, err);
        repeat (50) @(negedge clk);
        if (rd_cnt + wr_cnt != acc0) begin
            $display("memory was accessed after a start with a zero count");
            tb_errs++;
        end
        apb_access(OFS_STATUS, 1'b0, '0, rd, err);
        check_value("done", 0, rd[STS_DONE_BIT]);
        finish_test("zero_count", errs0);

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed,
                 tb_errs + chk_errs);
        if (tests_failed == 0 && tb_errs + chk_errs == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
